// File: include/hist_defs.svh
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

// coarse time code, one bin per code
`define HIST_BIN_W 3
`define HIST_BINS 8

// pixels in one frame and their index width
`define HIST_PIXELS 4
`define HIST_PIX_W 2

// advancing words per pixel before the pixel moves on
`define HIST_DATA_NUM 2
`define HIST_DATA_CNT_W 1

// acquisitions in one frame
`define HIST_ACQ_NUM 4
`define HIST_ACQ_W 2

// per-bin photon count
`define HIST_COUNT_W 8

// raw word from the TDC front end
`define HIST_WORD_W 16

// flat bank addressing, pixel times bins plus bin
`define HIST_ENTRIES (`HIST_PIXELS * `HIST_BINS)
`define HIST_ADDR_W 5

`endif

// File: logic/tdc_word_pkg.sv
`default_nettype none

package tdc_word_pkg;

    `include "hist_defs.svh"

    // hit flag set, the word carries a photon arrival
    typedef struct packed {
        logic                                   hit;
        logic [`HIST_BIN_W-1:0]                 coarse;
        logic [`HIST_WORD_W-`HIST_BIN_W-2:0]    fine;
    } tdc_photon_t;

    // hit flag clear, laser cycle with no photon
    typedef struct packed {
        logic                      hit;
        logic                      win_err;
        logic [`HIST_WORD_W-3:0]   rsvd;
    } tdc_empty_t;

    // same 16 bits, decoded by the hit flag
    typedef union packed {
        tdc_photon_t photon_view;
        tdc_empty_t  empty_view;
    } tdc_word_u;

    // decoded word, bin only meaningful for photons
    typedef struct packed {
        logic                   valid;
        logic                   is_photon;
        logic [`HIST_BIN_W-1:0] bin;
    } hit_event_t;

endpackage

`default_nettype wire

// File: logic/hist_mem_pkg.sv
`default_nettype none

package hist_mem_pkg;

    `include "hist_defs.svh"

    // one tagged word heading for the bank
    typedef struct packed {
        logic                   valid;
        logic                   is_photon;
        // last advancing word of the frame
        logic                   frame_last;
        logic [`HIST_PIX_W-1:0] pixel;
        logic [`HIST_BIN_W-1:0] bin;
    } bin_update_t;

    // one readout beat from the finished bank
    typedef struct packed {
        logic [`HIST_PIX_W-1:0]   pixel;
        logic [`HIST_BIN_W-1:0]   bin;
        logic [`HIST_COUNT_W-1:0] count;
    } bin_read_t;

endpackage

`default_nettype wire

// File: logic/tdc_word_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module tdc_word_decoder (
    input  wire                      clk,
    input  wire                      combin_res,
    input  wire                      wr_en,
    input  wire tdc_word_pkg::tdc_word_u raw_word,
    output tdc_word_pkg::hit_event_t hit_event
);

    import tdc_word_pkg::*;

    logic       wr_q;
    tdc_word_u  word_q;
    hit_event_t ev_next;

    // strobe stage
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            word_q <= raw_word;
        end
    end

    // pick the view by the hit flag
    always_comb begin
        ev_next = '0;
        if (wr_q) begin
            if (word_q.photon_view.hit) begin
                ev_next.valid     = 1'b1;
                ev_next.is_photon = 1'b1;
                ev_next.bin       = word_q.photon_view.coarse;
            end else begin
                // empty word, bin stays 0
                // window error kills it entirely
                ev_next.valid = ~word_q.empty_view.win_err;
            end
        end
    end

    // decode stage
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_event <= '0;
        end else begin
            hit_event <= ev_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/acq_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module acq_sequencer (
    input  wire                        clk,
    input  wire                        combin_res,
    input  wire tdc_word_pkg::hit_event_t hit_event,
    output hist_mem_pkg::bin_update_t  bin_upd
);

    import hist_mem_pkg::*;

    // nested counts, data inside pixel inside acquisition
    logic [`HIST_DATA_CNT_W-1:0] data_cnt;
    logic [`HIST_PIX_W-1:0]      pix_cnt;
    logic [`HIST_ACQ_W-1:0]      acq_cnt;

    logic        data_last;
    logic        pix_last;
    logic        acq_last;
    bin_update_t upd_next;

    assign data_last = (data_cnt == `HIST_DATA_NUM - 1);
    assign pix_last  = (pix_cnt == `HIST_PIXELS - 1);
    assign acq_last  = (acq_cnt == `HIST_ACQ_NUM - 1);

    // tag the event with where we are in the frame
    always_comb begin
        upd_next            = '0;
        upd_next.valid      = hit_event.valid;
        upd_next.is_photon  = hit_event.is_photon;
        upd_next.frame_last = hit_event.valid & data_last & pix_last & acq_last;
        upd_next.pixel      = pix_cnt;
        upd_next.bin        = hit_event.bin;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            data_cnt <= '0;
            pix_cnt  <= '0;
            acq_cnt  <= '0;
        end else if (hit_event.valid) begin
            if (!data_last) begin
                data_cnt <= data_cnt + 1'b1;
            end else begin
                data_cnt <= '0;
                // pixel done, move on
                if (!pix_last) begin
                    pix_cnt <= pix_cnt + 1'b1;
                end else begin
                    pix_cnt <= '0;
                    // last pixel, next acquisition
                    if (!acq_last) begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end else begin
                        // frame wraps, back to acquisition 0
                        acq_cnt <= '0;
                    end
                end
            end
        end
    end

    // one cycle behind the decoder
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bin_upd <= '0;
        end else begin
            bin_upd <= upd_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/hist_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module hist_bank (
    input  wire                           clk,
    input  wire                           combin_res,
    input  wire hist_mem_pkg::bin_update_t bin_upd,
    input  wire                           rd_en,
    input  wire [`HIST_PIX_W-1:0]         rd_addr_pixel,
    input  wire [`HIST_BIN_W-1:0]         rd_addr_bin,
    output logic [`HIST_COUNT_W-1:0]      rd_count,
    output logic [`HIST_COUNT_W-1:0]      bin_count,
    output logic                          update_valid,
    output logic                          frame_done,
    output logic                          bank_sel
);

    // ping-pong pair, bank_sel is the one being filled
    logic [`HIST_COUNT_W-1:0] mem [2][`HIST_ENTRIES];

    logic [`HIST_ADDR_W-1:0]  upd_addr;
    logic [`HIST_ADDR_W-1:0]  rd_addr;
    logic                     rd_bank;
    logic [`HIST_COUNT_W-1:0] cur_count;
    logic [`HIST_COUNT_W-1:0] new_count;

    assign upd_addr = `HIST_ADDR_W'(bin_upd.pixel * `HIST_BINS + bin_upd.bin);
    assign rd_addr  = `HIST_ADDR_W'(rd_addr_pixel * `HIST_BINS + rd_addr_bin);

    // readout always sees the finished bank
    assign rd_bank  = ~bank_sel;
    assign rd_count = mem[rd_bank][rd_addr];

    // read side of the read-modify-write
    assign cur_count = mem[bank_sel][upd_addr];

    // saturate at max, should never get there
    always_comb begin
        new_count = cur_count;
        if (bin_upd.is_photon && (cur_count != '1)) begin
            new_count = cur_count + 1'b1;
        end
    end

    // count arrays
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int b = 0; b < 2; b++) begin
                for (int e = 0; e < `HIST_ENTRIES; e++) begin
                    mem[b][e] <= '0;
                end
            end
        end else begin
            // empty words write back the same count
            if (bin_upd.valid) begin
                mem[bank_sel][upd_addr] <= new_count;
            end
            // clear as read, other bank so no clash
            if (rd_en) begin
                mem[rd_bank][rd_addr] <= '0;
            end
        end
    end

    // update strobe, frame end and swap
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            update_valid <= 1'b0;
            frame_done   <= 1'b0;
            bank_sel     <= 1'b0;
        end else begin
            update_valid <= bin_upd.valid;
            frame_done   <= bin_upd.valid & bin_upd.frame_last;
            if (bin_upd.valid && bin_upd.frame_last) begin
                // next update lands in the other bank
                bank_sel <= ~bank_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bin_upd.valid) begin
            bin_count <= new_count;
        end
    end

endmodule

`default_nettype wire

// File: logic/hist_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module hist_readout (
    input  wire                       clk,
    input  wire                       combin_res,
    input  wire                       frame_done,
    input  wire [`HIST_COUNT_W-1:0]   rd_count,
    output logic                      rd_en,
    output logic [`HIST_PIX_W-1:0]    rd_addr_pixel,
    output logic [`HIST_BIN_W-1:0]    rd_addr_bin,
    output logic                      rd_valid,
    output hist_mem_pkg::bin_read_t   rd_data
);

    import hist_mem_pkg::*;

    logic                    busy;
    // flat sweep index, bin in the low bits
    logic [`HIST_ADDR_W-1:0] sweep;
    logic                    sweep_last;
    bin_read_t               beat;

    // first read goes out in the frame_done cycle itself
    assign rd_en = frame_done | busy;

    // sweep sits at 0 when idle
    assign rd_addr_pixel = sweep[`HIST_ADDR_W-1:`HIST_BIN_W];
    assign rd_addr_bin   = sweep[`HIST_BIN_W-1:0];
    assign sweep_last    = (sweep == `HIST_ENTRIES - 1);

    always_comb begin
        beat.pixel = rd_addr_pixel;
        beat.bin   = rd_addr_bin;
        beat.count = rd_count;
    end

    // pixel-major sweep, bin fastest
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            busy     <= 1'b0;
            sweep    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            if (rd_en) begin
                // wraps back to 0 after the last bin
                sweep <= sweep + 1'b1;
                busy  <= ~sweep_last;
            end
        end
    end

    // beat registered with the count that came back
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= beat;
        end
    end

endmodule

`default_nettype wire

// File: logic/hist_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module hist_top (
    input  wire                          clk,
    input  wire                          combin_res,
    input  wire                          wr_en,
    input  wire tdc_word_pkg::tdc_word_u raw_word,
    output logic [`HIST_COUNT_W-1:0]     bin_count,
    output logic                         update_valid,
    output logic                         frame_done,
    output logic                         bank_sel,
    output logic                         rd_valid,
    output hist_mem_pkg::bin_read_t      rd_data
);

    import tdc_word_pkg::*;
    import hist_mem_pkg::*;

    hit_event_t  hit_event;
    bin_update_t bin_upd;

    // readout port between bank and streamer
    logic                     rd_en;
    logic [`HIST_PIX_W-1:0]   rd_addr_pixel;
    logic [`HIST_BIN_W-1:0]   rd_addr_bin;
    logic [`HIST_COUNT_W-1:0] rd_count;

    tdc_word_decoder u_decoder (
        .clk        (clk),
        .combin_res (combin_res),
        .wr_en      (wr_en),
        .raw_word   (raw_word),
        .hit_event  (hit_event)
    );

    acq_sequencer u_sequencer (
        .clk        (clk),
        .combin_res (combin_res),
        .hit_event  (hit_event),
        .bin_upd    (bin_upd)
    );

    hist_bank u_bank (
        .clk           (clk),
        .combin_res    (combin_res),
        .bin_upd       (bin_upd),
        .rd_en         (rd_en),
        .rd_addr_pixel (rd_addr_pixel),
        .rd_addr_bin   (rd_addr_bin),
        .rd_count      (rd_count),
        .bin_count     (bin_count),
        .update_valid  (update_valid),
        .frame_done    (frame_done),
        .bank_sel      (bank_sel)
    );

    hist_readout u_readout (
        .clk           (clk),
        .combin_res    (combin_res),
        .frame_done    (frame_done),
        .rd_count      (rd_count),
        .rd_en         (rd_en),
        .rd_addr_pixel (rd_addr_pixel),
        .rd_addr_bin   (rd_addr_bin),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data)
    );

endmodule

`default_nettype wire

// File: dv/hist_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module hist_checker (
    input wire                           clk,
    input wire                           combin_res,
    input wire                           wr_en,
    input wire [`HIST_WORD_W-1:0]        raw_word,
    input wire [`HIST_COUNT_W-1:0]       bin_count,
    input wire                           update_valid,
    input wire                           frame_done,
    input wire                           bank_sel,
    input wire                           rd_valid,
    input wire hist_mem_pkg::bin_read_t  rd_data
);

    import hist_mem_pkg::*;

    int err_count = 0;
    int frames_seen = 0;
    int beats_seen = 0;

    // model histogram pair and nested counters
    logic [`HIST_COUNT_W-1:0] hist [2][`HIST_ENTRIES];
    int   m_data;
    int   m_pix;
    int   m_acq;
    logic m_bank;
    logic exp_bank;

    // four stages, strobe to visible update_valid
    logic                     pv  [4];
    logic [`HIST_COUNT_W-1:0] pc  [4];
    logic                     pfd [4];

    bin_read_t beat_q [$];
    int        rd_left;

    logic                     nv;
    logic [`HIST_COUNT_W-1:0] nc;
    logic                     nfd;
    bin_read_t                exp_beat;

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        err_count++;
        $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
    endtask

    // counting rules applied to one strobed word
    task automatic model_word(input logic [`HIST_WORD_W-1:0] w, output logic v,
                              output logic [`HIST_COUNT_W-1:0] c, output logic fd);
        int idx;
        int bin;
        v   = 1'b0;
        c   = '0;
        fd  = 1'b0;
        // empty words report bin 0 of the pixel
        bin = w[15] ? int'(w[14:12]) : 0;
        idx = m_pix * `HIST_BINS + bin;
        if (w[15] || !w[14]) begin
            v = 1'b1;
            if (w[15] && hist[m_bank][idx] != '1) begin
                hist[m_bank][idx] = hist[m_bank][idx] + 1'b1;
            end
            c = hist[m_bank][idx];
            m_data++;
            if (m_data == `HIST_DATA_NUM) begin
                m_data = 0;
                m_pix++;
                if (m_pix == `HIST_PIXELS) begin
                    m_pix = 0;
                    m_acq++;
                    if (m_acq == `HIST_ACQ_NUM) begin
                        m_acq = 0;
                        fd    = 1'b1;
                        // finished bank becomes the readout stream, then reads as zero
                        for (int e = 0; e < `HIST_ENTRIES; e++) begin
                            exp_beat.pixel = `HIST_PIX_W'(e / `HIST_BINS);
                            exp_beat.bin   = `HIST_BIN_W'(e % `HIST_BINS);
                            exp_beat.count = hist[m_bank][e];
                            beat_q.push_back(exp_beat);
                            hist[m_bank][e] = '0;
                        end
                        m_bank = ~m_bank;
                    end
                end
            end
        end
    endtask

    always @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int b = 0; b < 2; b++) begin
                for (int e = 0; e < `HIST_ENTRIES; e++) begin
                    hist[b][e] = '0;
                end
            end
            for (int s = 0; s < 4; s++) begin
                pv[s]  = 1'b0;
                pc[s]  = '0;
                pfd[s] = 1'b0;
            end
            m_data   = 0;
            m_pix    = 0;
            m_acq    = 0;
            m_bank   = 1'b0;
            exp_bank = 1'b0;
            rd_left  = 0;
            beat_q.delete();
        end else begin
            // readout stream
            if (rd_valid !== (rd_left > 0)) begin
                mismatch("rd_valid", 32'(rd_left > 0), 32'(rd_valid));
            end
            if (rd_valid) begin
                beats_seen++;
                if (beat_q.size() == 0) begin
                    err_count++;
                    $display("readout beat arrived with none expected at %0t", $time);
                end else begin
                    exp_beat = beat_q.pop_front();
                    if (rd_data !== exp_beat) begin
                        mismatch("rd_data", 32'(exp_beat), 32'(rd_data));
                    end
                end
            end
            if (rd_left > 0) begin
                rd_left--;
            end

            // live update path
            if (update_valid !== pv[3]) begin
                mismatch("update_valid", 32'(pv[3]), 32'(update_valid));
            end else if (pv[3] && bin_count !== pc[3]) begin
                mismatch("bin_count", 32'(pc[3]), 32'(bin_count));
            end
            if (frame_done !== pfd[3]) begin
                mismatch("frame_done", 32'(pfd[3]), 32'(frame_done));
            end
            if (frame_done) begin
                frames_seen++;
            end
            if (pfd[3]) begin
                exp_bank = ~exp_bank;
                rd_left  = `HIST_ENTRIES;
            end
            if (bank_sel !== exp_bank) begin
                mismatch("bank_sel", 32'(exp_bank), 32'(bank_sel));
            end

            for (int s = 3; s > 0; s--) begin
                pv[s]  = pv[s-1];
                pc[s]  = pc[s-1];
                pfd[s] = pfd[s-1];
            end
            nv  = 1'b0;
            nc  = '0;
            nfd = 1'b0;
            if (wr_en) begin
                model_word(raw_word, nv, nc, nfd);
            end
            pv[0]  = nv;
            pc[0]  = nc;
            pfd[0] = nfd;
        end
    end

endmodule

`default_nettype wire

// File: dv/hist_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module hist_asserts (
    input wire clk,
    input wire combin_res,
    input wire frame_done,
    input wire rd_valid,
    input wire bank_sel
);

    // failed properties so far
    int fail_count = 0;

    // frame end is a single pulse
    a_fd_single: assert property (@(posedge clk) disable iff (!combin_res)
        frame_done |=> !frame_done)
        else begin
            fail_count++;
            $error("frame_done wider than one cycle");
        end

    // readout finishes before the next frame ends
    a_fd_no_overlap: assert property (@(posedge clk) disable iff (!combin_res)
        frame_done |-> !rd_valid)
        else begin
            fail_count++;
            $error("frame_done during readout");
        end

    a_rd_start: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(rd_valid) |-> $past(frame_done))
        else begin
            fail_count++;
            $error("rd_valid rose without frame_done");
        end

    // swap happens on the same edge as frame_done
    a_bank_swap: assert property (@(posedge clk) disable iff (!combin_res)
        $changed(bank_sel) |-> frame_done)
        else begin
            fail_count++;
            $error("bank_sel changed without frame_done");
        end

endmodule

bind hist_top hist_asserts u_asserts (
    .clk        (clk),
    .combin_res (combin_res),
    .frame_done (frame_done),
    .rd_valid   (rd_valid),
    .bank_sel   (bank_sel)
);

`default_nettype wire

// File: dv/hist_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module hist_tb;

    import tdc_word_pkg::*;
    import hist_mem_pkg::*;

    localparam int NUM_ROWS   = 34;
    localparam int FRAME_WORDS = `HIST_DATA_NUM * `HIST_PIXELS * `HIST_ACQ_NUM;

    logic                      clk;
    logic                      combin_res;
    logic                      wr_en;
    tdc_word_u                 raw_word;
    logic [`HIST_COUNT_W-1:0]  bin_count;
    logic                      update_valid;
    logic                      frame_done;
    logic                      bank_sel;
    logic                      rd_valid;
    bin_read_t                 rd_data;

    // stimulus table, one word and its idle gap per row
    // bit 15 hit, 14:12 coarse or 14 window error
    logic [`HIST_WORD_W-1:0] tbl_word [NUM_ROWS] = '{
        16'h8101, 16'h8102, 16'h4000, 16'h9003, 16'h0000, 16'hf7ff,
        16'hf000, 16'h4abc, 16'ha011, 16'h0000, 16'hb123, 16'hb456,
        16'hc000, 16'hd000, 16'h0000, 16'h0123, 16'he000, 16'h8000,
        16'h8001, 16'h8002, 16'h9000, 16'ha000, 16'hb000, 16'hc001,
        16'hd002, 16'he003, 16'hf004, 16'h0000, 16'h8fff, 16'h8eee,
        16'h9ddd, 16'h9ccc, 16'h0000, 16'hf111
    };
    int tbl_gap [NUM_ROWS] = '{
        0, 0, 1, 0, 2, 0,
        0, 0, 3, 0, 0, 0,
        1, 0, 0, 2, 0, 0,
        0, 0, 1, 1, 0, 0,
        4, 0, 0, 0, 0, 0,
        2, 0, 0, 1
    };

    integer seed;
    int     timeout_count;
    int     adv;
    logic [31:0] rnd;
    logic [31:0] rnd_gap;

    always #5 clk = ~clk;

    hist_top u_dut (
        .clk          (clk),
        .combin_res   (combin_res),
        .wr_en        (wr_en),
        .raw_word     (raw_word),
        .bin_count    (bin_count),
        .update_valid (update_valid),
        .frame_done   (frame_done),
        .bank_sel     (bank_sel),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data)
    );

    hist_checker u_chk (
        .clk          (clk),
        .combin_res   (combin_res),
        .wr_en        (wr_en),
        .raw_word     (raw_word),
        .bin_count    (bin_count),
        .update_valid (update_valid),
        .frame_done   (frame_done),
        .bank_sel     (bank_sel),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data)
    );

    // one strobe, then gap idle cycles
    task automatic send_word(input logic [`HIST_WORD_W-1:0] w, input int gap);
        @(posedge clk);
        wr_en    <= 1'b1;
        raw_word <= w;
        for (int i = 0; i < gap; i++) begin
            @(posedge clk);
            wr_en <= 1'b0;
        end
    endtask

    // three frames in total, each with a full readout
    task automatic wait_all_frames();
        int i;
        i = 0;
        while (!(u_chk.frames_seen == 3 && u_chk.beats_seen == 3 * `HIST_ENTRIES)
               && i < 4000) begin
            @(posedge clk);
            i++;
        end
        if (i >= 4000) begin
            timeout_count++;
            $display("timeout: frames or readout beats did not all arrive");
        end
    endtask

    initial begin
        clk           = 1'b0;
        combin_res    = 1'b0;
        wr_en         = 1'b0;
        raw_word      = '0;
        seed          = 32'h082632cf;
        timeout_count = 0;
        adv           = 0;

        repeat (8) @(posedge clk);
        combin_res <= 1'b1;
        // idle stretch, outputs must stay quiet
        repeat (5) @(posedge clk);

        // directed frame from the table
        for (int r = 0; r < NUM_ROWS; r++) begin
            send_word(tbl_word[r], tbl_gap[r]);
        end

        // two random frames, error words do not count toward the frame
        while (adv < 2 * FRAME_WORDS) begin
            rnd     = $random(seed);
            rnd_gap = $random(seed);
            if (rnd[15] || !rnd[14]) begin
                adv++;
            end
            send_word(rnd[15:0], int'(rnd_gap[1:0]));
        end
        @(posedge clk);
        wr_en <= 1'b0;

        wait_all_frames();
        repeat (4) @(posedge clk);

        $display("errors: %0d mismatches, %0d assertion failures, %0d timeouts",
                 u_chk.err_count, u_dut.u_asserts.fail_count, timeout_count);
        if (u_chk.err_count == 0 && u_dut.u_asserts.fail_count == 0
            && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
logic/tdc_word_pkg.sv
logic/hist_mem_pkg.sv
logic/tdc_word_decoder.sv
logic/acq_sequencer.sv
logic/hist_bank.sv
logic/hist_readout.sv
logic/hist_top.sv
dv/hist_checker.sv
dv/hist_asserts.sv
dv/hist_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the histogram testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module hist_tb \
    --Mdir obj_dir -o sim_hist > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_hist > sim.log 2>&1
cat sim.log

! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log && exit 0 || exit 1
